/* source/decode_cfg.svh */
// Widths, PC alignment and major opcode values for the decode stage
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

`define XLEN        32
`define REG_AW      5
`define ALIGN_BITS  2

// Major opcodes, bits [6:0] of the word
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OP_IMM   7'b0010011
`define OPC_OP       7'b0110011
`define OPC_MISC_MEM 7'b0001111
`define OPC_SYSTEM   7'b1110011

`endif

/* source/decode_pkg.sv */
// Operation and format enums, fetch, issue and source-use structs
`include "decode_cfg.svh"

package decode_pkg;

    // Decoded operation, NOP must stay at zero since it is the bubble value
    typedef enum logic [5:0] {
        NOP, INVALID,
        LUI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        JAL, JALR,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        ECALL, EBREAK, SRET, MRET, WFI
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } format_e;

    // Word and PC from fetch
    typedef struct packed {
        logic [`XLEN-1:0] instr;
        logic [`XLEN-1:0] pc;
    } fetch_t;

    // Registered result handed to execute
    typedef struct packed {
        op_e              op;
        logic [`XLEN-1:0] first;
        logic [`XLEN-1:0] second;
        logic [`XLEN-1:0] third;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
        logic             illegal;
        logic             misaligned;
    } issue_t;

    // Which source registers a format reads
    typedef struct packed {
        logic rs1;
        logic rs2;
    } src_use_t;

endpackage

/* source/op_decoder.sv */
// Operation, format and illegal-instruction decode of the current word
`include "decode_cfg.svh"

module op_decoder
    import decode_pkg::*;
(
    input  logic [`XLEN-1:0] instr_i,
    output op_e              op_o,
    output format_e          format_o,
    output logic             illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_e        dec_branch;
    op_e        dec_load;
    op_e        dec_store;
    op_e        dec_op_imm;
    op_e        dec_op;
    op_e        dec_system;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////
    // Per-class lookups
    ////////////////////////////////////////

    always_comb begin
        unique case (funct3)
            3'b000:  dec_branch = BEQ;
            3'b001:  dec_branch = BNE;
            3'b100:  dec_branch = BLT;
            3'b101:  dec_branch = BGE;
            3'b110:  dec_branch = BLTU;
            3'b111:  dec_branch = BGEU;
            default: dec_branch = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  dec_load = LB;
            3'b001:  dec_load = LH;
            3'b010:  dec_load = LW;
            3'b100:  dec_load = LBU;
            3'b101:  dec_load = LHU;
            default: dec_load = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  dec_store = SB;
            3'b001:  dec_store = SH;
            3'b010:  dec_store = SW;
            default: dec_store = INVALID;
        endcase
    end

    // Shifts need an exact funct7, the rest ignore it
    always_comb begin
        unique case ({funct7, funct3}) inside
            10'b???????000: dec_op_imm = ADD;
            10'b0000000001: dec_op_imm = SLL;
            10'b???????010: dec_op_imm = SLT;
            10'b???????011: dec_op_imm = SLTU;
            10'b???????100: dec_op_imm = XOR;
            10'b0000000101: dec_op_imm = SRL;
            10'b0100000101: dec_op_imm = SRA;
            10'b???????110: dec_op_imm = OR;
            10'b???????111: dec_op_imm = AND;
            default:        dec_op_imm = INVALID;
        endcase
    end

    always_comb begin
        unique case ({funct7, funct3})
            10'b0000000000: dec_op = ADD;
            10'b0100000000: dec_op = SUB;
            10'b0000000001: dec_op = SLL;
            10'b0000000010: dec_op = SLT;
            10'b0000000011: dec_op = SLTU;
            10'b0000000100: dec_op = XOR;
            10'b0000000101: dec_op = SRL;
            10'b0100000101: dec_op = SRA;
            10'b0000000110: dec_op = OR;
            10'b0000000111: dec_op = AND;
            // M extension
            10'b0000001000: dec_op = MUL;
            10'b0000001001: dec_op = MULH;
            10'b0000001010: dec_op = MULHSU;
            10'b0000001011: dec_op = MULHU;
            10'b0000001100: dec_op = DIV;
            10'b0000001101: dec_op = DIVU;
            10'b0000001110: dec_op = REM;
            10'b0000001111: dec_op = REMU;
            default:        dec_op = INVALID;
        endcase
    end

    // Privileged ops match the whole upper field, CSR ops only funct3
    always_comb begin
        unique case (instr_i[31:7]) inside
            25'b0000000000000000000000000: dec_system = ECALL;
            25'b0000000000010000000000000: dec_system = EBREAK;
            25'b0001000000100000000000000: dec_system = SRET;
            25'b0011000000100000000000000: dec_system = MRET;
            25'b0001000001010000000000000: dec_system = WFI;
            25'b?????????????????001?????: dec_system = CSRRW;
            25'b?????????????????010?????: dec_system = CSRRS;
            25'b?????????????????011?????: dec_system = CSRRC;
            25'b?????????????????101?????: dec_system = CSRRWI;
            25'b?????????????????110?????: dec_system = CSRRSI;
            25'b?????????????????111?????: dec_system = CSRRCI;
            default:                       dec_system = INVALID;
        endcase
    end

    ////////////////////////////////////////
    // Major opcode select
    ////////////////////////////////////////

    always_comb begin
        unique case (opcode)
            `OPC_LUI:      op_o = LUI;
            `OPC_AUIPC:    op_o = ADD;
            `OPC_JAL:      op_o = JAL;
            `OPC_JALR:     op_o = JALR;
            `OPC_BRANCH:   op_o = dec_branch;
            `OPC_LOAD:     op_o = dec_load;
            `OPC_STORE:    op_o = dec_store;
            `OPC_OP_IMM:   op_o = dec_op_imm;
            `OPC_OP:       op_o = dec_op;
            `OPC_MISC_MEM: op_o = (funct3 == 3'b000) ? NOP : INVALID;
            `OPC_SYSTEM:   op_o = dec_system;
            default:       op_o = INVALID;
        endcase
    end

    always_comb begin
        unique case (opcode)
            `OPC_JALR, `OPC_LOAD, `OPC_OP_IMM: format_o = I_TYPE;
            `OPC_STORE:                        format_o = S_TYPE;
            `OPC_BRANCH:                       format_o = B_TYPE;
            `OPC_LUI, `OPC_AUIPC:              format_o = U_TYPE;
            `OPC_JAL:                          format_o = J_TYPE;
            default:                           format_o = R_TYPE;
        endcase
    end

    assign illegal_o = (op_o == INVALID);

endmodule

/* source/operand_unit.sv */
// Immediate generation and selection of the three operands
`include "decode_cfg.svh"

module operand_unit
    import decode_pkg::*;
(
    input  logic [`XLEN-1:0] instr_i,
    input  logic [`XLEN-1:0] pc_i,
    input  format_e          format_i,
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    output logic [`XLEN-1:0] first_o,
    output logic [`XLEN-1:0] second_o,
    output logic [`XLEN-1:0] third_o
);

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm;

    ////////////////////////////////////////
    // Immediate layouts, sign from bit 31
    ////////////////////////////////////////

    assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
    assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        unique case (format_i)
            I_TYPE:  imm = imm_i;
            S_TYPE:  imm = imm_s;
            B_TYPE:  imm = imm_b;
            U_TYPE:  imm = imm_u;
            J_TYPE:  imm = imm_j;
            default: imm = '0;
        endcase
    end

    ////////////////////////////////////////
    // Operand muxes
    ////////////////////////////////////////

    // PC feeds AUIPC, LUI and JAL
    assign first_o  = (format_i == U_TYPE || format_i == J_TYPE) ? pc_i : rs1_data_i;
    assign second_o = (format_i == R_TYPE) ? rs2_data_i : imm;
    // Store data rides on the third operand
    assign third_o  = (format_i == S_TYPE) ? rs2_data_i : imm;

endmodule

/* source/hazard_ctrl.sv */
// Word replay, register lock, hazard detection and rd delay
`include "decode_cfg.svh"

module hazard_ctrl
    import decode_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               enable_i,
    input  logic [`XLEN-1:0]   fetch_instr_i,
    input  format_e            format_i,
    output logic [`XLEN-1:0]   cur_instr_o,
    output logic [`REG_AW-1:0] rs1_o,
    output logic [`REG_AW-1:0] rs2_o,
    output logic [`REG_AW-1:0] rd_o,
    output logic               hazard_o
);

    logic [`XLEN-1:0]   last_instr;
    logic               last_hazard;
    logic               last_stall;
    logic [`REG_AW-1:0] lock_reg;
    logic               lock_store;
    logic [6:0]         opcode;
    src_use_t           src_use;
    logic               hazard_rs1;
    logic               hazard_rs2;
    logic               hazard_mem;

    ////////////////////////////////////////
    // Replay of the held word
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        last_instr <= cur_instr_o;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_hazard <= 1'b0;
            last_stall  <= 1'b0;
        end else begin
            last_hazard <= hazard_o;
            last_stall  <= ~enable_i;
        end
    end

    assign cur_instr_o = (last_hazard || last_stall) ? last_instr : fetch_instr_i;
    assign opcode      = cur_instr_o[6:0];
    assign rs1_o       = cur_instr_o[15 +: `REG_AW];
    assign rs2_o       = cur_instr_o[20 +: `REG_AW];

    ////////////////////////////////////////
    // Lock register and rd delay
    ////////////////////////////////////////

    // A hazard drops the lock, so the bubble lasts one cycle
    always_ff @(posedge clk) begin
        if (reset || hazard_o) begin
            lock_reg   <= '0;
            lock_store <= 1'b0;
        end else if (enable_i) begin
            lock_reg   <= cur_instr_o[7 +: `REG_AW];
            lock_store <= (opcode == `OPC_STORE);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_o <= '0;
        end else begin
            rd_o <= lock_reg;
        end
    end

    ////////////////////////////////////////
    // Hazard detection
    ////////////////////////////////////////

    always_comb begin
        unique case (format_i)
            R_TYPE, S_TYPE, B_TYPE: src_use = '{rs1: 1'b1, rs2: 1'b1};
            I_TYPE:                 src_use = '{rs1: 1'b1, rs2: 1'b0};
            default:                src_use = '{rs1: 1'b0, rs2: 1'b0};
        endcase
    end

    // x0 never locks
    assign hazard_rs1 = src_use.rs1 && (lock_reg != '0) && (lock_reg == rs1_o);
    assign hazard_rs2 = src_use.rs2 && (lock_reg != '0) && (lock_reg == rs2_o);
    assign hazard_mem = lock_store && (opcode == `OPC_LOAD);
    assign hazard_o   = enable_i && (hazard_rs1 || hazard_rs2 || hazard_mem);

endmodule

/* source/issue_reg.sv */
// Issue register with bubble insertion, stall hold and exception flags
`include "decode_cfg.svh"

module issue_reg
    import decode_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             enable_i,
    input  logic             hazard_i,
    input  op_e              op_i,
    input  logic [`XLEN-1:0] instr_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic             illegal_i,
    input  logic [`XLEN-1:0] first_i,
    input  logic [`XLEN-1:0] second_i,
    input  logic [`XLEN-1:0] third_i,
    output issue_t           issue_o
);

    // Bubble is a NOP with everything else cleared
    localparam issue_t BUBBLE = '{op: NOP, default: '0};

    logic misaligned;

    assign misaligned = (pc_i[`ALIGN_BITS-1:0] != '0);

    // Low enable holds the last issue
    always_ff @(posedge clk) begin
        if (reset || hazard_i) begin
            issue_o <= BUBBLE;
        end else if (enable_i) begin
            issue_o.op         <= op_i;
            issue_o.first      <= first_i;
            issue_o.second     <= second_i;
            issue_o.third      <= third_i;
            issue_o.pc         <= pc_i;
            issue_o.instr      <= instr_i;
            issue_o.illegal    <= illegal_i;
            issue_o.misaligned <= misaligned;
        end
    end

endmodule

/* source/decode_stage.sv */
// Decode stage top level connecting control, decoder, operands and issue register
`include "decode_cfg.svh"

module decode_stage
    import decode_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               enable_i,
    input  fetch_t             fetch_i,
    input  logic [`XLEN-1:0]   rs1_data_i,
    input  logic [`XLEN-1:0]   rs2_data_i,
    output logic [`REG_AW-1:0] rs1_o,
    output logic [`REG_AW-1:0] rs2_o,
    output logic [`REG_AW-1:0] rd_o,
    output logic               hazard_o,
    output issue_t             issue_o
);

    logic [`XLEN-1:0] cur_instr;
    op_e              op;
    format_e          fmt;
    logic             illegal;
    logic [`XLEN-1:0] first;
    logic [`XLEN-1:0] second;
    logic [`XLEN-1:0] third;

    hazard_ctrl u_hazard_ctrl (
        .clk           (clk),
        .reset         (reset),
        .enable_i      (enable_i),
        .fetch_instr_i (fetch_i.instr),
        .format_i      (fmt),
        .cur_instr_o   (cur_instr),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .rd_o          (rd_o),
        .hazard_o      (hazard_o)
    );

    op_decoder u_op_decoder (
        .instr_i   (cur_instr),
        .op_o      (op),
        .format_o  (fmt),
        .illegal_o (illegal)
    );

    operand_unit u_operand_unit (
        .instr_i    (cur_instr),
        .pc_i       (fetch_i.pc),
        .format_i   (fmt),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .first_o    (first),
        .second_o   (second),
        .third_o    (third)
    );

    issue_reg u_issue_reg (
        .clk       (clk),
        .reset     (reset),
        .enable_i  (enable_i),
        .hazard_i  (hazard_o),
        .op_i      (op),
        .instr_i   (cur_instr),
        .pc_i      (fetch_i.pc),
        .illegal_i (illegal),
        .first_i   (first),
        .second_i  (second),
        .third_i   (third),
        .issue_o   (issue_o)
    );

endmodule

/* test/tb_clock.sv */
// Free-running clock generator for the testbench
module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

/* test/decode_assert.sv */
// Concurrent hazard and bubble assertions bound to the decode stage
`include "decode_cfg.svh"

module decode_assert
    import decode_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   enable_i,
    input logic   hazard_o,
    input issue_t issue_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // A stall never raises a hazard
    hazard_needs_enable: assert property (@(posedge clk) disable iff (reset)
        hazard_o |-> enable_i)
        else $error("hazard raised while enable is low");

    hazard_gives_bubble: assert property (@(posedge clk) disable iff (reset)
        hazard_o |=> (issue_o.op == NOP))
        else $error("no bubble after hazard");

    // Lock is cleared by the hazard itself
    hazard_one_cycle: assert property (@(posedge clk) disable iff (reset)
        hazard_o |=> !hazard_o)
        else $error("hazard lasted two cycles");

endmodule

bind decode_stage decode_assert u_decode_assert (
    .clk      (clk),
    .reset    (reset),
    .enable_i (enable_i),
    .hazard_o (hazard_o),
    .issue_o  (issue_o)
);

/* test/decode_tb.sv */
// Directed tests, register-file model, compare tasks, LFSR and watchdog
`include "decode_cfg.svh"

module decode_tb
    import decode_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam int WATCHDOG_CYCLES = 400;
    localparam logic [31:0] FLUSH_WORD = 32'h00000013;

    logic               clk;
    logic               reset;
    logic               enable_i;
    fetch_t             fetch_i;
    logic [`XLEN-1:0]   rs1_data_i;
    logic [`XLEN-1:0]   rs2_data_i;
    logic [`REG_AW-1:0] rs1_o;
    logic [`REG_AW-1:0] rs2_o;
    logic [`REG_AW-1:0] rd_o;
    logic               hazard_o;
    issue_t             issue_o;

    logic [31:0] lfsr_state = 32'hc466f1a0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk(clk));

    decode_stage i_dut (
        .clk        (clk),
        .reset      (reset),
        .enable_i   (enable_i),
        .fetch_i    (fetch_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .rs1_o      (rs1_o),
        .rs2_o      (rs2_o),
        .rd_o       (rd_o),
        .hazard_o   (hazard_o),
        .issue_o    (issue_o)
    );

    ////////////////////////////////////////
    // Register file model and LFSR
    ////////////////////////////////////////

    function automatic logic [31:0] reg_val(input logic [4:0] r);
        return {27'b0, r} * 32'h01010101;
    endfunction

    assign rs1_data_i = reg_val(rs1_o);
    assign rs2_data_i = reg_val(rs2_o);

    // Taps 32, 22, 2, 1
    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Nonzero register not in the avoid list
    function logic [4:0] pick_reg(input logic [4:0] a, input logic [4:0] b);
        logic [4:0] r;
        r = 5'(rand_bits(5));
        while (r == 0 || r == a || r == b) begin
            r = 5'(rand_bits(5));
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    ////////////////////////////////////////
    // Compare tasks and drivers
    ////////////////////////////////////////

    task automatic check_op(input string what, input op_e got, input op_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s op %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_word(input string what, input logic [`XLEN-1:0] got,
                              input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_issue(input string what, input op_e op, input logic [31:0] first,
                               input logic [31:0] second, input logic [31:0] third,
                               input logic [31:0] pc, input logic [31:0] instr);
        check_op(what, issue_o.op, op);
        check_word({what, " first"}, issue_o.first, first);
        check_word({what, " second"}, issue_o.second, second);
        check_word({what, " third"}, issue_o.third, third);
        check_word({what, " pc"}, issue_o.pc, pc);
        check_word({what, " instr"}, issue_o.instr, instr);
    endtask

    // Inputs change 5 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic present(input logic [31:0] w, input logic [31:0] pc);
        fetch_i = '{instr: w, pc: pc};
    endtask

    task automatic check_hazard(input string what, input logic exp);
        #1;
        check_flag({what, " hazard"}, hazard_o, exp);
    endtask

    // Clears the lock before a test
    task automatic flush();
        present(FLUSH_WORD, 32'h0);
        tick();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("test %s done, %0d errors", name, errors - errors_before);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic alu_decode_test();
        int          e0;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] imm;
        e0 = errors;
        for (int k = 0; k < 5; k++) begin
            rs1 = pick_reg(0, 0);
            rs2 = pick_reg(rs1, 0);
            rd  = pick_reg(rs1, rs2);
            sh  = 5'(rand_bits(5));
            pc  = {30'(rand_bits(30)), 2'b00};
            flush();
            case (k)
                0: w = enc_r(7'b0000000, rs2, rs1, 3'b000, rd, `OPC_OP);
                1: w = enc_r(7'b0100000, rs2, rs1, 3'b000, rd, `OPC_OP);
                2: w = enc_r(7'b0000001, rs2, rs1, 3'b000, rd, `OPC_OP);
                3: w = enc_i({7'b0000000, sh}, rs1, 3'b001, rd, `OPC_OP_IMM);
                default: w = enc_i({7'b0100000, sh}, rs1, 3'b101, rd, `OPC_OP_IMM);
            endcase
            // Shift immediates, R format has none
            imm = (k == 4) ? {20'b0, 7'b0100000, sh} : {27'b0, sh};
            present(w, pc);
            tick();
            case (k)
                0: check_issue("add", ADD, reg_val(rs1), reg_val(rs2), 32'h0, pc, w);
                1: check_issue("sub", SUB, reg_val(rs1), reg_val(rs2), 32'h0, pc, w);
                2: check_issue("mul", MUL, reg_val(rs1), reg_val(rs2), 32'h0, pc, w);
                3: check_issue("slli", SLL, reg_val(rs1), imm, imm, pc, w);
                default: check_issue("srai", SRA, reg_val(rs1), imm, imm, pc, w);
            endcase
            present(FLUSH_WORD, 32'h0);
            tick();
            check_word("rd_o", {27'b0, rd_o}, {27'b0, rd});
        end
        finish_test("alu_decode", e0);
    endtask

    task automatic immediate_test();
        int          e0;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] imm;
        e0 = errors;
        for (int k = 0; k < 6; k++) begin
            rs1 = pick_reg(0, 0);
            rs2 = pick_reg(rs1, 0);
            rd  = pick_reg(rs1, rs2);
            pc  = {30'(rand_bits(30)), 2'b00};
            flush();
            case (k)
                0: begin
                    imm = rand_bits(12);
                    w = enc_i(imm[11:0], rs1, 3'b010, rd, `OPC_LOAD);
                    imm = {{20{imm[11]}}, imm[11:0]};
                end
                1: begin
                    imm = rand_bits(12);
                    w = enc_s(imm[11:0], rs2, rs1, 3'b010);
                    imm = {{20{imm[11]}}, imm[11:0]};
                end
                2: begin
                    imm = {19'b0, 12'(rand_bits(12)), 1'b0};
                    w = enc_b(imm[12:0], rs2, rs1, 3'b000);
                    imm = {{19{imm[12]}}, imm[12:0]};
                end
                3, 4: begin
                    imm = {20'(rand_bits(20)), 12'b0};
                    w = {imm[31:12], rd, (k == 3) ? `OPC_LUI : `OPC_AUIPC};
                end
                default: begin
                    imm = {11'b0, 20'(rand_bits(20)), 1'b0};
                    w = enc_j(imm[20:0], rd);
                    imm = {{11{imm[20]}}, imm[20:0]};
                end
            endcase
            present(w, pc);
            tick();
            case (k)
                0: check_issue("lw", LW, reg_val(rs1), imm, imm, pc, w);
                1: check_issue("sw", SW, reg_val(rs1), imm, reg_val(rs2), pc, w);
                2: check_issue("beq", BEQ, reg_val(rs1), imm, imm, pc, w);
                3: check_issue("lui", LUI, pc, imm, imm, pc, w);
                4: check_issue("auipc", ADD, pc, imm, imm, pc, w);
                default: check_issue("jal", JAL, pc, imm, imm, pc, w);
            endcase
        end
        finish_test("immediates", e0);
    endtask

    task automatic register_hazard_test();
        int          e0;
        logic [31:0] sub_w;
        logic [31:0] next_w;
        e0 = errors;
        flush();
        present(enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd5, `OPC_OP), 32'h100);
        check_hazard("add x5", 1'b0);
        tick();
        sub_w = enc_r(7'b0100000, 5'd7, 5'd5, 3'b000, 5'd6, `OPC_OP);
        present(sub_w, 32'h104);
        check_hazard("sub after add", 1'b1);
        tick();
        check_op("bubble", issue_o.op, NOP);
        next_w = enc_i(12'h012, 5'd0, 3'b000, 5'd8, `OPC_OP_IMM);
        present(next_w, 32'h108);
        check_hazard("replay", 1'b0);
        tick();
        check_issue("replayed sub", SUB, reg_val(5), reg_val(7), 32'h0, 32'h108, sub_w);
        flush();
        // Writes to x0 never lock
        present(enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd0, `OPC_OP), 32'h200);
        tick();
        present(enc_r(7'b0100000, 5'd0, 5'd0, 3'b000, 5'd3, `OPC_OP), 32'h204);
        check_hazard("x0 dependency", 1'b0);
        tick();
        flush();
        present(enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd9, `OPC_OP), 32'h300);
        tick();
        // rs2 field of this ADDI equals x9
        present(enc_i(12'h009, 5'd1, 3'b000, 5'd10, `OPC_OP_IMM), 32'h304);
        check_hazard("i-format rs2 field", 1'b0);
        tick();
        check_op("addi", issue_o.op, ADD);
        finish_test("register_hazard", e0);
    endtask

    task automatic memory_hazard_test();
        int          e0;
        logic [31:0] lw_w;
        e0 = errors;
        flush();
        present(enc_s(12'h000, 5'd4, 5'd3, 3'b010), 32'h400);
        tick();
        lw_w = enc_i(12'h010, 5'd2, 3'b010, 5'd11, `OPC_LOAD);
        present(lw_w, 32'h404);
        check_hazard("load after store", 1'b1);
        tick();
        check_op("store-load bubble", issue_o.op, NOP);
        check_hazard("load replay", 1'b0);
        tick();
        check_op("replayed load", issue_o.op, LW);
        check_word("replayed load instr", issue_o.instr, lw_w);
        flush();
        present(enc_i(12'h020, 5'd2, 3'b010, 5'd12, `OPC_LOAD), 32'h500);
        tick();
        present(enc_i(12'h024, 5'd2, 3'b010, 5'd13, `OPC_LOAD), 32'h504);
        check_hazard("load after load", 1'b0);
        tick();
        check_op("second load", issue_o.op, LW);
        finish_test("memory_hazard", e0);
    endtask

    task automatic stall_test();
        int          e0;
        issue_t      held;
        logic [31:0] xor_w;
        e0 = errors;
        flush();
        present(enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, `OPC_OP), 32'h600);
        tick();
        held = issue_o;
        // Depends on x3 and would hazard without the stall
        xor_w = enc_r(7'b0000000, 5'd5, 5'd3, 3'b100, 5'd6, `OPC_OP);
        present(xor_w, 32'h604);
        enable_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            check_hazard("stalled", 1'b0);
            tick();
            check_word("stalled issue instr", issue_o.instr, held.instr);
            check_op("stalled issue op", issue_o.op, held.op);
            // Fetch moves on while the stage is stalled
            present(FLUSH_WORD, 32'h608);
        end
        enable_i = 1'b1;
        check_hazard("resume", 1'b1);
        tick();
        check_op("resume bubble", issue_o.op, NOP);
        tick();
        check_issue("held xor", XOR, reg_val(3), reg_val(5), 32'h0, 32'h608, xor_w);
        finish_test("stall", e0);
    endtask

    task automatic exception_test();
        int e0;
        e0 = errors;
        flush();
        present(32'h0000_0057, 32'h700);
        tick();
        check_op("op-v", issue_o.op, INVALID);
        check_flag("op-v illegal", issue_o.illegal, 1'b1);
        present(enc_r(7'b0000010, 5'd2, 5'd1, 3'b000, 5'd3, `OPC_OP), 32'h704);
        tick();
        check_op("bad funct7", issue_o.op, INVALID);
        check_flag("bad funct7 illegal", issue_o.illegal, 1'b1);
        present(enc_i(12'h001, 5'd1, 3'b000, 5'd3, `OPC_OP_IMM), 32'h70a);
        tick();
        check_flag("misaligned pc", issue_o.misaligned, 1'b1);
        check_flag("aligned word illegal", issue_o.illegal, 1'b0);
        flush();
        check_flag("aligned pc", issue_o.misaligned, 1'b0);
        finish_test("exceptions", e0);
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        reset    = 1'b1;
        enable_i = 1'b1;
        fetch_i  = '{instr: FLUSH_WORD, pc: 32'h0};
        repeat (4) @(posedge clk);
        #5;
        reset = 1'b0;
        check_issue("reset", NOP, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0);
        check_flag("reset illegal", issue_o.illegal, 1'b0);
        check_flag("reset misaligned", issue_o.misaligned, 1'b0);
        alu_decode_test();
        immediate_test();
        register_hazard_test();
        memory_hazard_test();
        stall_test();
        exception_test();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+source
source/decode_pkg.sv
source/op_decoder.sv
source/operand_unit.sv
source/hazard_ctrl.sv
source/issue_reg.sv
source/decode_stage.sv
test/tb_clock.sv
test/decode_assert.sv
test/decode_tb.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP        := decode_tb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "PASS: all tests" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
